//--- hw/lock_defines.svh
`ifndef LOCK_DEFINES_SVH
`define LOCK_DEFINES_SVH

// stored code, three BCD digits
`define LOCK_CODE 12'h246

// failed tries before lockout
`define MAX_TRIES 4'd6

// key click: slow toggle, short burst (cycles)
`define CLICK_HALF_PERIOD 16'd4
`define CLICK_LENGTH 16'd24

// success tone: faster toggle, longer burst
`define OK_HALF_PERIOD 16'd2
`define OK_LENGTH 16'd48

`define DISP_BLANK 12'hfff
`define DISP_OPEN 12'hbcc
`define DISP_LOCKED 12'h000

`endif

//--- hw/lock_pkg.sv
package lock_pkg;

    // key codes, digits keep their BCD value
    typedef enum logic [3:0] {
        key_0     = 4'd0,
        key_1     = 4'd1,
        key_2     = 4'd2,
        key_3     = 4'd3,
        key_4     = 4'd4,
        key_5     = 4'd5,
        key_6     = 4'd6,
        key_7     = 4'd7,
        key_8     = 4'd8,
        key_9     = 4'd9,
        key_enter = 4'd10,
        key_clear = 4'd11,
        key_reset = 4'd12
    } key_code_e;

    typedef enum logic [1:0] {
        st_entry   = 2'd0,
        st_open    = 2'd1,
        st_lockout = 2'd2
    } lock_state_e;

    typedef enum logic {
        tone_click   = 1'b0,
        tone_success = 1'b1
    } tone_e;

endpackage

//--- hw/key_decoder.sv
`timescale 1ns/1ps

module key_decoder
    import lock_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    output logic        key_valid,
    output key_code_e   key
);

    logic [15:0] onehot_q;    // registered keypad lines
    logic [15:0] prev_q;      // sample one cycle older
    logic        map_valid;
    key_code_e   map_key;

    // single mapped line to key code, anything else rejected
    always_comb begin
        map_valid = 1'b1;
        map_key   = key_0;
        case (onehot_q)
            16'h0008: map_key = key_0;
            16'h0080: map_key = key_1;
            16'h0040: map_key = key_2;
            16'h0020: map_key = key_3;
            16'h0800: map_key = key_4;
            16'h0400: map_key = key_5;
            16'h0200: map_key = key_6;
            16'h8000: map_key = key_7;
            16'h4000: map_key = key_8;
            16'h2000: map_key = key_9;
            16'h0001: map_key = key_enter;
            16'h1000: map_key = key_clear;
            16'h0100: map_key = key_reset;
            default:  map_valid = 1'b0;   // idle, unused line or several keys
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            onehot_q  <= '0;
            prev_q    <= '0;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;
            prev_q    <= onehot_q;
            // press counts only when coming out of idle
            key_valid <= map_valid && (prev_q == '0);
        end
    end

    // key code only meaningful with the strobe
    always_ff @(posedge clk) begin
        key <= map_key;
    end

endmodule

//--- hw/code_lock_fsm.sv
`timescale 1ns/1ps

`include "lock_defines.svh"

module code_lock_fsm
    import lock_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        key_valid,
    input  key_code_e   key,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [3:0]  tries,
    output logic        unlocked,
    output logic        locked_out,
    output logic        tone_start,
    output tone_e       tone
);

    lock_state_e state;
    logic [3:0]  digit;        // BCD value of a digit key
    logic [3:0]  tries_next;
    logic        code_match;
    logic        entry_full;

    assign digit      = key;
    assign tries_next = tries + 4'd1;
    assign code_match = (display == `LOCK_CODE);
    assign entry_full = (digit_count == 2'd3);

    assign unlocked   = (state == st_open);
    assign locked_out = (state == st_lockout);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_entry;
            display     <= `DISP_BLANK;
            digit_count <= 2'd0;
            tries       <= 4'd0;
            tone_start  <= 1'b0;
            tone        <= tone_click;
        end else begin
            tone_start <= key_valid;   // every accepted key sounds
            if (key_valid) begin
                tone <= tone_click;
                case (key)
                    key_reset: begin
                        // works from any state, also drops the try count
                        state       <= st_entry;
                        display     <= `DISP_BLANK;
                        digit_count <= 2'd0;
                        tries       <= 4'd0;
                    end
                    key_clear: begin
                        if (state != st_lockout) begin
                            state       <= st_entry;
                            display     <= `DISP_BLANK;
                            digit_count <= 2'd0;
                        end
                    end
                    key_enter: begin
                        if (state == st_entry && entry_full) begin
                            if (code_match) begin
                                state   <= st_open;
                                display <= `DISP_OPEN;
                                tone    <= tone_success;   // replaces the click
                            end else begin
                                display     <= `DISP_BLANK;
                                digit_count <= 2'd0;
                                tries       <= tries_next;
                                if (tries_next == `MAX_TRIES) begin
                                    state   <= st_lockout;
                                    display <= `DISP_LOCKED;
                                end
                            end
                        end
                    end
                    default: begin
                        // digit: shift in from the right, fourth one dropped
                        if (state == st_entry && !entry_full) begin
                            display     <= {display[7:0], digit};
                            digit_count <= digit_count + 2'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/buzzer_driver.sv
`timescale 1ns/1ps

`include "lock_defines.svh"

module buzzer_driver
    import lock_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  tone_start,
    input  tone_e tone,
    output logic  buzzer
);

    localparam int CNT_W = 16;

    tone_e            tone_q;       // tone being played
    logic             active;
    logic [CNT_W-1:0] half_cnt;     // cycles since last toggle
    logic [CNT_W-1:0] len_cnt;      // cycles since start
    logic [CNT_W-1:0] half_sel;
    logic [CNT_W-1:0] len_sel;

    // success tone is higher and lasts longer
    assign half_sel = (tone_q == tone_success) ? `OK_HALF_PERIOD : `CLICK_HALF_PERIOD;
    assign len_sel  = (tone_q == tone_success) ? `OK_LENGTH : `CLICK_LENGTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            tone_q   <= tone_click;
            active   <= 1'b0;
            half_cnt <= '0;
            len_cnt  <= '0;
            buzzer   <= 1'b0;
        end else if (tone_start) begin
            // new request always restarts, whatever is playing
            tone_q   <= tone;
            active   <= 1'b1;
            half_cnt <= '0;
            len_cnt  <= '0;
            buzzer   <= 1'b1;
        end else if (active) begin
            half_cnt <= half_cnt + 1'b1;
            len_cnt  <= len_cnt + 1'b1;
            if (half_cnt == half_sel - 1'b1) begin
                buzzer   <= ~buzzer;
                half_cnt <= '0;
            end
            if (len_cnt == len_sel - 1'b1) begin
                active <= 1'b0;
                buzzer <= 1'b0;   // end of burst, output parked low
            end
        end
    end

endmodule

//--- hw/code_lock_top.sv
`timescale 1ns/1ps

module code_lock_top
    import lock_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [3:0]  tries,
    output logic        unlocked,
    output logic        locked_out,
    output logic        buzzer
);

    logic      key_valid;
    key_code_e key;
    logic      tone_start;
    tone_e     tone;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key       (key)
    );

    code_lock_fsm u_code_lock_fsm (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key         (key),
        .display     (display),
        .digit_count (digit_count),
        .tries       (tries),
        .unlocked    (unlocked),
        .locked_out  (locked_out),
        .tone_start  (tone_start),
        .tone        (tone)
    );

    buzzer_driver u_buzzer_driver (
        .clk        (clk),
        .rst        (rst),
        .tone_start (tone_start),
        .tone       (tone),
        .buzzer     (buzzer)
    );

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;   // 10 ns period

endmodule

//--- testbench/code_lock_checker.sv
`timescale 1ns/1ps

`include "lock_defines.svh"

module code_lock_checker (
    input logic        clk,
    input logic        rst,
    input logic        key_valid,
    input logic [11:0] display,
    input logic [1:0]  digit_count,
    input logic        unlocked,
    input logic        locked_out
);

    // decoder strobe lasts one cycle only
    property single_cycle_strobe;
        @(posedge clk) disable iff (rst) !(key_valid && $past(key_valid));
    endproperty

    // open and lockout each keep their own display word
    property open_display;
        @(posedge clk) disable iff (rst) unlocked |-> display == `DISP_OPEN;
    endproperty

    property lockout_display;
        @(posedge clk) disable iff (rst) locked_out |-> display == `DISP_LOCKED;
    endproperty

    // count moves only after a strobe, one step up or back to zero
    property count_step;
        @(posedge clk) disable iff (rst)
            (digit_count != $past(digit_count)) |->
                ($past(key_valid) &&
                 (digit_count == $past(digit_count) + 2'd1 || digit_count == 2'd0));
    endproperty

    a_single_strobe: assert property (single_cycle_strobe)
        else $error("key_valid was high on two cycles in a row");

    a_open_display: assert property (open_display)
        else $error("unlocked is high without the open display word");

    a_lockout_display: assert property (lockout_display)
        else $error("locked_out is high without the lockout display word");

    a_count_step: assert property (count_step)
        else $error("digit_count changed without a key strobe or by a wrong step");

endmodule

//--- testbench/code_lock_tb.sv
`timescale 1ns/1ps

`include "lock_defines.svh"

module code_lock_tb
    import lock_pkg::*;
();

    localparam int NUM_PRESSES     = 50;
    localparam int WATCHDOG_CYCLES = NUM_PRESSES * 30 + `OK_LENGTH + `CLICK_LENGTH;

    logic        clk;
    logic        rst;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  digit_count;
    logic [3:0]  tries;
    logic        unlocked;
    logic        locked_out;
    logic        buzzer;

    // expected lock registers, kept by the lock rules
    logic [11:0] exp_display;
    logic [1:0]  exp_count;
    logic [3:0]  exp_tries;
    lock_state_e exp_state;

    int error_count = 0;
    int check_count = 0;

    tb_clk_gen u_clk_gen (.clk(clk));

    code_lock_top uut (
        .clk         (clk),
        .rst         (rst),
        .onehot      (onehot),
        .display     (display),
        .digit_count (digit_count),
        .tries       (tries),
        .unlocked    (unlocked),
        .locked_out  (locked_out),
        .buzzer      (buzzer)
    );

    bind code_lock_top code_lock_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .display     (display),
        .digit_count (digit_count),
        .unlocked    (unlocked),
        .locked_out  (locked_out)
    );

    // keypad wiring, line number per key
    function automatic logic [15:0] key_line(input key_code_e k);
        case (k)
            key_0:     return 16'h0008;
            key_1:     return 16'h0080;
            key_2:     return 16'h0040;
            key_3:     return 16'h0020;
            key_4:     return 16'h0800;
            key_5:     return 16'h0400;
            key_6:     return 16'h0200;
            key_7:     return 16'h8000;
            key_8:     return 16'h4000;
            key_9:     return 16'h2000;
            key_enter: return 16'h0001;
            key_clear: return 16'h1000;
            default:   return 16'h0100;   // reset key
        endcase
    endfunction

    task automatic check_field(input string tag, input string name,
                               input logic [11:0] got, input logic [11:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s: %s is %h, expected %h", $time, tag, name, got, exp);
        end
    endtask

    task automatic check_model(input string tag);
        check_field(tag, "display", display, exp_display);
        check_field(tag, "digit_count", 12'(digit_count), 12'(exp_count));
        check_field(tag, "tries", 12'(tries), 12'(exp_tries));
        check_field(tag, "unlocked", 12'(unlocked), 12'(exp_state == st_open));
        check_field(tag, "locked_out", 12'(locked_out), 12'(exp_state == st_lockout));
    endtask

    // effect of one accepted key on the expected registers
    task automatic apply_rules(input key_code_e k);
        logic [3:0] d;
        d = k;
        if (k == key_reset) begin
            exp_state   = st_entry;
            exp_display = `DISP_BLANK;
            exp_count   = 2'd0;
            exp_tries   = 4'd0;
        end else if (k == key_clear) begin
            if (exp_state != st_lockout) begin
                exp_state   = st_entry;
                exp_display = `DISP_BLANK;
                exp_count   = 2'd0;
            end
        end else if (k == key_enter) begin
            if (exp_state == st_entry && exp_count == 2'd3) begin
                if (exp_display == `LOCK_CODE) begin
                    exp_state   = st_open;
                    exp_display = `DISP_OPEN;
                end else begin
                    exp_display = `DISP_BLANK;
                    exp_count   = 2'd0;
                    exp_tries   = exp_tries + 4'd1;
                    if (exp_tries == `MAX_TRIES) begin
                        exp_state   = st_lockout;
                        exp_display = `DISP_LOCKED;
                    end
                end
            end
        end else if (exp_state == st_entry && exp_count != 2'd3) begin
            exp_display = {exp_display[7:0], d};
            exp_count   = exp_count + 2'd1;
        end
    endtask

    // hold lines, release for 6 cycles, end on a falling edge
    task automatic drive_lines(input logic [15:0] lines, input int hold);
        @(posedge clk);
        onehot <= lines;
        repeat (hold) @(posedge clk);
        onehot <= '0;
        repeat (6) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic press_key(input key_code_e k, input int hold);
        drive_lines(key_line(k), hold);
        apply_rules(k);
        check_model(k.name());
    endtask

    task automatic enter_code(input key_code_e d2, input key_code_e d1, input key_code_e d0);
        press_key(d2, 3);
        press_key(d1, 3);
        press_key(d0, 3);
        press_key(key_enter, 3);
    endtask

    task automatic test_digit_entry();
        check_model("after reset");
        check_field("after reset", "buzzer", 12'(buzzer), 12'd0);
        press_key(key_2, 3);
        press_key(key_4, 3);
        press_key(key_6, 3);
        check_field("entry", "display", display, 12'h246);
        press_key(key_7, 3);   // fourth digit only clicks
    endtask

    task automatic test_open();
        int   toggles;
        logic last;
        toggles = 0;
        press_key(key_enter, 3);
        check_field("open", "display", display, `DISP_OPEN);
        last = buzzer;
        repeat (`OK_LENGTH + 16) begin
            @(negedge clk);
            if (buzzer != last) toggles++;
            last = buzzer;
        end
        // success tone keeps toggling far longer than a click could
        check_count++;
        if (toggles < `OK_LENGTH / (2 * `OK_HALF_PERIOD)) begin
            error_count++;
            $display("FAIL @%0t: success tone toggled %0d times, expected at least %0d",
                     $time, toggles, `OK_LENGTH / (2 * `OK_HALF_PERIOD));
        end
        check_field("tone end", "buzzer", 12'(buzzer), 12'd0);
        press_key(key_5, 3);
        press_key(key_reset, 3);
    endtask

    task automatic test_wrong_code();
        enter_code(key_1, key_3, key_5);
        check_field("wrong code", "tries", 12'(tries), 12'd1);
    endtask

    task automatic test_lockout();
        while (exp_state != st_lockout) begin
            enter_code(key_9, key_9, key_9);
        end
        check_field("lockout", "display", display, `DISP_LOCKED);
        press_key(key_2, 3);
        press_key(key_clear, 3);
        press_key(key_reset, 3);
    endtask

    task automatic test_odd_input();
        press_key(key_3, 12);   // held key counts once
        drive_lines(key_line(key_3) | key_line(key_7), 3);
        check_model("two keys");
        drive_lines(16'h0002, 3);
        check_model("unused line");
        press_key(key_3, 3);
        check_field("repeat digit", "display", display, 12'hf33);
        press_key(key_clear, 3);
    endtask

    task automatic test_clear_then_open();
        press_key(key_2, 3);
        press_key(key_4, 3);
        press_key(key_clear, 3);
        enter_code(key_2, key_4, key_6);
        check_field("reopen", "unlocked", 12'(unlocked), 12'd1);
        press_key(key_reset, 3);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        onehot      = '0;
        exp_display = `DISP_BLANK;
        exp_count   = 2'd0;
        exp_tries   = 4'd0;
        exp_state   = st_entry;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_digit_entry();
        test_open();
        test_wrong_code();
        test_lockout();
        test_odd_input();
        test_clear_then_open();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/lock_pkg.sv
hw/key_decoder.sv
hw/code_lock_fsm.sv
hw/buzzer_driver.sv
hw/code_lock_top.sv
testbench/tb_clk_gen.sv
testbench/code_lock_checker.sv
testbench/code_lock_tb.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all run check clean

all: check

obj_dir/Vcode_lock_tb: filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module code_lock_tb -f filelist.f

run: obj_dir/Vcode_lock_tb
	./obj_dir/Vcode_lock_tb | tee sim.log

check: run
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
